/* Makefile */
TOP = obj_engine_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)
	verilator --lint-only -Wall source/obj_pkg.sv source/fb_pkg.sv source/obj_position_eval.sv \
		source/obj_tile_shifter.sv source/obj_list_walker.sv source/obj_engine.sv \
		--top-module obj_engine

clean:
	rm -rf obj_dir $(LOG)

/* sim/obj_engine_tb.sv */
`timescale 1ns/1ns

module obj_engine_tb;
    import obj_pkg::*;
    import fb_pkg::*;

    localparam int sprites_drawn = 12;
    localparam int watchdog_cycles = 3 * 835 * 12 + 200 * sprites_drawn + 200;

    logic clk;
    logic reset;
    logic frame_start;
    logic busy;
    logic page;
    obj_ram_addr_t list_addr;
    obj_word_t list_data;
    logic tile_req_valid;
    logic tile_req_ready;
    tile_addr_t tile_req_addr;
    logic tile_rdata_valid;
    fb_word_t tile_rdata;
    logic fb_valid;
    logic fb_ready;
    fb_addr_t fb_addr;
    fb_word_t fb_data;
    fb_be_t fb_be;
    logic tile_stall;
    logic data_gap;
    logic fb_stall;

    logic [31:0] rng;
    int mismatch_count;
    int other_count;

    // reference state of the position latches
    logic [11:0] ref_master_x;
    logic [11:0] ref_master_y;
    logic [11:0] ref_extra_x;
    logic [11:0] ref_extra_y;
    logic [11:0] ref_x;
    logic [11:0] ref_y;
    logic [7:0] ref_colour;
    logic ref_flip;

    logic [18:0] exp_tile[$];
    logic [15:0] exp_addr[$];
    logic [63:0] exp_data[$];
    logic [7:0] exp_be[$];

    logic hold;
    logic [15:0] hold_addr;
    logic [63:0] hold_data;
    logic [7:0] hold_be;

    obj_engine dut (
        .clk(clk), .reset(reset), .frame_start(frame_start), .busy(busy), .page(page),
        .list_addr(list_addr), .list_data(list_data),
        .tile_req_valid(tile_req_valid), .tile_req_ready(tile_req_ready),
        .tile_req_addr(tile_req_addr), .tile_rdata_valid(tile_rdata_valid),
        .tile_rdata(tile_rdata), .fb_valid(fb_valid), .fb_ready(fb_ready),
        .fb_addr(fb_addr), .fb_data(fb_data), .fb_be(fb_be)
    );

    obj_mem_model mem (
        .clk(clk), .reset(reset), .list_addr(list_addr), .list_data(list_data),
        .tile_req_valid(tile_req_valid), .tile_req_ready(tile_req_ready),
        .tile_req_addr(tile_req_addr), .tile_rdata_valid(tile_rdata_valid),
        .tile_rdata(tile_rdata), .fb_ready(fb_ready),
        .tile_stall(tile_stall), .data_gap(data_gap), .fb_stall(fb_stall)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [5:0] tile_pixel(input logic [13:0] code, input int r, input int q);
        logic [63:0] w;
        logic [31:0] d;
        int k;
        w = mem.tile_mem[(int'(code) * 32 + 2 * r + q / 8) % 1024];
        d = ((q % 8) / 4 != 0) ? w[63:32] : w[31:0];
        k = q % 4;
        return {d[16 + 2 * k +: 2], d[4 * k +: 4]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    // 16 rows of five words per sprite
    task automatic push_sprite(input logic pg, input logic [13:0] code);
        logic [63:0] data;
        logic [7:0] be;
        logic [5:0] px;
        int i;
        exp_tile.push_back(19'(code) * 19'd32);
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 5; c++) begin
                for (int p = 0; p < 4; p++) begin
                    i = 4 * c + p - int'(ref_x[1:0]);
                    px = '0;
                    if (i >= 0 && i < 16) begin
                        px = tile_pixel(code, r, ref_flip ? 15 - i : i);
                    end
                    data[16 * p +: 16] = {4'b0000, ref_colour[7:2], px};
                    be[2 * p +: 2] = {2{|px}};
                end
                exp_addr.push_back({pg, 8'(ref_y[7:0] + 8'(r)), 7'(ref_x[8:2] + 7'(c))});
                exp_data.push_back(data);
                exp_be.push_back(be);
            end
        end
    endtask

    task automatic run_model(input logic pg);
        logic [15:0] tw;
        logic [15:0] cw;
        logic [15:0] xw;
        logic [15:0] yw;
        logic [11:0] sx;
        logic [11:0] sy;
        logic [11:0] bx;
        logic [11:0] by;
        for (int e = 0; e < obj_entry_count; e++) begin
            tw = mem.sprite_ram[e * 8 + obj_tile_word];
            cw = mem.sprite_ram[e * 8 + obj_colour_word];
            xw = mem.sprite_ram[e * 8 + obj_x_word];
            yw = mem.sprite_ram[e * 8 + obj_y_word];
            sx = '0;
            sy = '0;
            if (!xw[obj_absolute_bit]) begin
                sx = ref_master_x;
                sy = ref_master_y;
                if (!xw[obj_no_extra_bit]) begin
                    sx = sx + ref_extra_x;
                    sy = sy + ref_extra_y;
                end
            end
            bx = xw[11:0] + sx;
            by = yw[11:0] + sy;
            if (xw[obj_latch_master_bit]) begin
                ref_master_x = bx;
                ref_master_y = by;
            end
            if (xw[obj_latch_extra_bit]) begin
                ref_extra_x = bx;
                ref_extra_y = by;
            end
            ref_x = (cw[obj_use_cur_x_bit] ? bx : ref_x) + (cw[obj_inc_x_bit] ? 12'd16 : 12'd0);
            ref_y = (cw[obj_use_cur_y_bit] ? by : ref_y) + (cw[obj_inc_y_bit] ? 12'd16 : 12'd0);
            if (!cw[obj_reuse_colour_bit]) begin
                ref_colour = cw[7:0];
            end
            ref_flip = cw[obj_flip_x_bit];
            if (tw[13:0] != 0 && ref_x <= 12'd480 && ref_y <= 12'd240) begin
                push_sprite(pg, tw[13:0]);
            end
        end
    endtask

    task automatic put_entry(input int idx, input logic [15:0] tw, input logic [15:0] cw,
                             input logic [15:0] xw, input logic [15:0] yw);
        mem.sprite_ram[idx * 8 + obj_tile_word] = tw;
        mem.sprite_ram[idx * 8 + obj_colour_word] = cw;
        mem.sprite_ram[idx * 8 + obj_x_word] = xw;
        mem.sprite_ram[idx * 8 + obj_y_word] = yw;
    endtask

    task automatic pulse_frame();
        logic old_page;
        @(posedge clk);
        old_page = page;
        #2 frame_start = 1'b1;
        @(posedge clk);
        #2 frame_start = 1'b0;
        assert (page == !old_page) else begin
            $display("page did not toggle on frame_start");
            other_count++;
        end
    endtask

    task automatic wait_walk_end();
        while (busy) begin
            @(negedge clk);
        end
        assert (exp_addr.size() == 0 && exp_tile.size() == 0) else begin
            $display("walk ended with %0d fb words and %0d tile requests missing",
                     exp_addr.size(), exp_tile.size());
            other_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // random stalls on both ports and gaps in the tile burst
    always @(posedge clk) begin
        #2;
        rng = lcg_next(rng);
        tile_stall = rng[9:8] == 2'b00;
        data_gap = rng[13:12] == 2'b00;
        fb_stall = rng[17:16] == 2'b00;
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (hold) begin
                assert (fb_valid && fb_addr == hold_addr && fb_data == hold_data &&
                        fb_be == hold_be) else begin
                    $display("fb outputs changed while fb_ready was low");
                    other_count++;
                end
            end
            hold = fb_valid && !fb_ready;
            hold_addr = fb_addr;
            hold_data = fb_data;
            hold_be = fb_be;
            if (tile_req_valid && tile_req_ready) begin
                if (exp_tile.size() == 0) begin
                    $display("tile request for an entry that should be skipped");
                    other_count++;
                end else begin
                    check_value("tile_addr", 64'(exp_tile.pop_front()), 64'(tile_req_addr));
                end
            end
            if (fb_valid && fb_ready) begin
                if (exp_addr.size() == 0) begin
                    $display("fb write with no expected word left");
                    other_count++;
                end else begin
                    check_value("fb_addr", 64'(exp_addr.pop_front()), 64'(fb_addr));
                    check_value("fb_data", exp_data.pop_front(), fb_data);
                    check_value("fb_be", 64'(exp_be.pop_front()), 64'(fb_be));
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the walk never finished", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rng = 32'hd7e2_0ef0;
        reset = 1'b1;
        frame_start = 1'b0;
        tile_stall = 1'b0;
        data_gap = 1'b0;
        fb_stall = 1'b0;
        mismatch_count = 0;
        other_count = 0;
        hold = 1'b0;
        {ref_master_x, ref_master_y, ref_extra_x, ref_extra_y} = '0;
        {ref_x, ref_y, ref_colour, ref_flip} = '0;
        for (int a = 0; a < 32768; a++) begin
            mem.sprite_ram[a] = '0;
        end
        for (int a = 0; a < 1024; a++) begin
            rng = lcg_next(rng);
            mem.tile_mem[a][31:0] = rng ^ 32'(a);
            rng = lcg_next(rng);
            mem.tile_mem[a][63:32] = rng;
        end
        // latch entries, then scrolled, sequence, no-extra and absolute sprites
        put_entry(0, 16'h0000, 16'h0000, 16'hA064, 16'h0032);
        put_entry(1, 16'h0000, 16'h0000, 16'h9008, 16'h0004);
        put_entry(2, 16'h0005, 16'h50B4, 16'h0014, 16'h000A);
        put_entry(3, 16'h0006, 16'h8500, 16'h0000, 16'h0000);
        put_entry(4, 16'h0007, 16'h505C, 16'h401E, 16'h0014);
        put_entry(5, 16'h0009, 16'h51FF, 16'h81DD, 16'h00E6);
        // just outside the drawing area
        put_entry(7, 16'h0003, 16'h5010, 16'h81E1, 16'h0000);
        put_entry(8, 16'h0004, 16'h5010, 16'h8000, 16'h00F1);
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        assert (!busy && !tile_req_valid && !fb_valid && page == 1'b0) else begin
            $display("outputs not idle after reset");
            other_count++;
        end

        run_model(1'b1);
        pulse_frame();
        wait_walk_end();

        // second frame is cut short by a third frame_start
        run_model(1'b0);
        pulse_frame();
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        assert (busy) else begin
            $display("walk ended before the abort could be tested");
            other_count++;
        end
        run_model(1'b1);
        pulse_frame();
        wait_walk_end();

        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/obj_mem_model.sv */
`timescale 1ns/1ns

module obj_mem_model (
    input  logic                   clk,
    input  logic                   reset,
    input  obj_pkg::obj_ram_addr_t list_addr,
    output obj_pkg::obj_word_t     list_data,
    input  logic                   tile_req_valid,
    output logic                   tile_req_ready,
    input  fb_pkg::tile_addr_t     tile_req_addr,
    output logic                   tile_rdata_valid,
    output fb_pkg::fb_word_t       tile_rdata,
    output logic                   fb_ready,
    input  logic                   tile_stall,
    input  logic                   data_gap,
    input  logic                   fb_stall
);
    import fb_pkg::*;

    logic [15:0] sprite_ram [32768];
    // tile codes below 32 only
    fb_word_t    tile_mem [1024];

    logic        burst_active;
    logic [9:0]  burst_base;
    logic [4:0]  burst_cnt;

    // sprite RAM has one cycle of read latency
    always_ff @(posedge clk) begin
        list_data <= sprite_ram[list_addr];
    end

    assign tile_req_ready = !burst_active && !tile_stall;
    assign tile_rdata_valid = burst_active && !data_gap;
    assign tile_rdata = tile_mem[burst_base + 10'(burst_cnt)];
    assign fb_ready = !fb_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            burst_active <= 1'b0;
            burst_cnt <= '0;
            burst_base <= '0;
        end else if (tile_req_valid && tile_req_ready) begin
            burst_active <= 1'b1;
            burst_base <= tile_req_addr[9:0];
            burst_cnt <= '0;
        end else if (tile_rdata_valid) begin
            burst_cnt <= burst_cnt + 5'd1;
            if (burst_cnt == 5'd31) begin
                burst_active <= 1'b0;
            end
        end
    end

endmodule

/* source/fb_pkg.sv */
package fb_pkg;

    localparam int fb_row_bits = 8;
    localparam int fb_col_bits = 7;
    localparam int fb_pixels_per_word = 4;

    // drawing area limits
    localparam int fb_max_x = 480;
    localparam int fb_max_y = 240;

    localparam int tile_size = 16;
    localparam int tile_burst_len = 32;
    // a shifted row may spill into a fifth word
    localparam int shifter_cols = 5;

    // page bit, row, word column
    typedef logic [fb_row_bits+fb_col_bits:0] fb_addr_t;
    typedef logic [63:0] fb_word_t;
    typedef logic [7:0]  fb_be_t;
    typedef logic [18:0] tile_addr_t;
    typedef logic [5:0]  pixel_t;

endpackage

/* source/obj_engine.sv */
`timescale 1ns/1ns

module obj_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   frame_start,
    output logic                   busy,
    output logic                   page,
    output obj_pkg::obj_ram_addr_t list_addr,
    input  obj_pkg::obj_word_t     list_data,
    output logic                   tile_req_valid,
    input  logic                   tile_req_ready,
    output fb_pkg::tile_addr_t     tile_req_addr,
    input  logic                   tile_rdata_valid,
    input  fb_pkg::fb_word_t       tile_rdata,
    output logic                   fb_valid,
    input  logic                   fb_ready,
    output fb_pkg::fb_addr_t       fb_addr,
    output fb_pkg::fb_word_t       fb_data,
    output fb_pkg::fb_be_t         fb_be
);
    import obj_pkg::*;
    import fb_pkg::*;

    logic                           load;
    fb_word_t                       load_data;
    logic                           tile_start;
    logic                           out_valid;
    logic                           out_ready;
    logic                           out_last;
    logic [fb_row_bits+fb_col_bits-1:0] out_addr;
    obj_coord_t                     x;
    obj_coord_t                     y;
    obj_colour_t                    colour;
    logic                           flip_x;

    // draw page flips with every frame
    always_ff @(posedge clk) begin
        if (reset) begin
            page <= 1'b0;
        end else if (frame_start) begin
            page <= ~page;
        end
    end

    obj_list_walker u_walker (
        .clk             (clk),
        .reset           (reset),
        .frame_start     (frame_start),
        .page            (page),
        .busy            (busy),
        .list_addr       (list_addr),
        .list_data       (list_data),
        .tile_req_valid  (tile_req_valid),
        .tile_req_ready  (tile_req_ready),
        .tile_req_addr   (tile_req_addr),
        .tile_rdata_valid(tile_rdata_valid),
        .tile_rdata      (tile_rdata),
        .fb_valid        (fb_valid),
        .fb_ready        (fb_ready),
        .fb_addr         (fb_addr),
        .load            (load),
        .load_data       (load_data),
        .tile_start      (tile_start),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_last        (out_last),
        .out_addr        (out_addr),
        .x               (x),
        .y               (y),
        .colour          (colour),
        .flip_x          (flip_x)
    );

    // pixel data and enables go straight to the fb port
    obj_tile_shifter u_shifter (
        .clk       (clk),
        .reset     (reset),
        .tile_start(tile_start),
        .load      (load),
        .load_data (load_data),
        .x         (x),
        .y         (y),
        .colour    (colour),
        .flip_x    (flip_x),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_addr  (out_addr),
        .out_data  (fb_data),
        .out_be    (fb_be),
        .out_last  (out_last)
    );

endmodule

/* source/obj_list_walker.sv */
`timescale 1ns/1ns

module obj_list_walker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  frame_start,
    input  logic                  page,
    output logic                  busy,
    output obj_pkg::obj_ram_addr_t list_addr,
    input  obj_pkg::obj_word_t    list_data,
    output logic                  tile_req_valid,
    input  logic                  tile_req_ready,
    output fb_pkg::tile_addr_t    tile_req_addr,
    input  logic                  tile_rdata_valid,
    input  fb_pkg::fb_word_t      tile_rdata,
    output logic                  fb_valid,
    input  logic                  fb_ready,
    output fb_pkg::fb_addr_t      fb_addr,
    output logic                  load,
    output fb_pkg::fb_word_t      load_data,
    output logic                  tile_start,
    input  logic                  out_valid,
    output logic                  out_ready,
    input  logic                  out_last,
    input  logic [fb_pkg::fb_row_bits+fb_pkg::fb_col_bits-1:0] out_addr,
    output obj_pkg::obj_coord_t   x,
    output obj_pkg::obj_coord_t   y,
    output obj_pkg::obj_colour_t  colour,
    output logic                  flip_x
);
    import obj_pkg::*;
    import fb_pkg::*;

    walker_state_t  state;
    obj_entry_idx_t entry_idx;
    logic [2:0]     word_idx;
    logic [2:0]     cap_idx;
    logic           cap_en;
    logic           abort_pending;
    obj_word_t      tile_word;
    obj_word_t      colour_word;
    obj_word_t      x_word;
    obj_word_t      y_word;
    obj_tile_code_t tile_code;
    logic           draw_ok;

    obj_position_eval u_eval (
        .clk        (clk),
        .reset      (reset),
        .eval_start (state == st_eval),
        .x_word     (x_word),
        .y_word     (y_word),
        .colour_word(colour_word),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .flip_x     (flip_x)
    );

    assign list_addr = obj_ram_addr_t'({entry_idx, word_idx});
    assign tile_code = tile_word[$bits(obj_tile_code_t)-1:0];
    // 32 words per tile
    assign tile_req_addr = {tile_code, 5'b00000};
    assign tile_req_valid = (state == st_tile_req);
    assign busy = (state != st_idle);
    assign tile_start = (state == st_eval);
    assign load = tile_rdata_valid && (state == st_draw);
    assign load_data = tile_rdata;

    // fb port is the shifter output with the page bit on top
    assign fb_valid = out_valid && (state == st_draw);
    assign out_ready = fb_ready && (state == st_draw);
    assign fb_addr = {page, out_addr};

    assign draw_ok = (tile_code != '0) &&
                     (x <= obj_coord_t'(fb_max_x)) &&
                     (y <= obj_coord_t'(fb_max_y));

    // list_data lags list_addr by one cycle
    always_ff @(posedge clk) begin
        cap_idx <= word_idx;
        if (cap_en) begin
            if (cap_idx == 3'(obj_tile_word)) begin
                tile_word <= list_data;
            end
            if (cap_idx == 3'(obj_colour_word)) begin
                colour_word <= list_data;
            end
            if (cap_idx == 3'(obj_x_word)) begin
                x_word <= list_data;
            end
            if (cap_idx == 3'(obj_y_word)) begin
                y_word <= list_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            entry_idx <= '0;
            word_idx <= '0;
            cap_en <= 1'b0;
            abort_pending <= 1'b0;
        end else begin
            cap_en <= (state == st_read);
            // new frame during a walk, honoured at the next entry boundary
            if (frame_start && state != st_idle) begin
                abort_pending <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (frame_start) begin
                        entry_idx <= '0;
                        word_idx <= '0;
                        state <= st_read;
                    end
                end
                st_read: begin
                    word_idx <= word_idx + 3'd1;
                    if (word_idx == 3'(obj_words_per_entry - 1)) begin
                        state <= st_read_last;
                    end
                end
                st_read_last: state <= st_eval;
                st_eval: state <= st_check;
                st_check: state <= draw_ok ? st_tile_req : st_next;
                st_tile_req: begin
                    if (tile_req_ready) begin
                        state <= st_draw;
                    end
                end
                st_draw: begin
                    if (out_valid && fb_ready && out_last) begin
                        state <= st_next;
                    end
                end
                st_next: begin
                    abort_pending <= 1'b0;
                    if (abort_pending || frame_start) begin
                        entry_idx <= '0;
                        state <= st_read;
                    end else if (entry_idx == obj_entry_idx_t'(obj_entry_count - 1)) begin
                        state <= st_idle;
                    end else begin
                        entry_idx <= entry_idx + 1'b1;
                        state <= st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* source/obj_pkg.sv */
package obj_pkg;

    typedef logic [15:0] obj_word_t;
    typedef logic [14:0] obj_ram_addr_t;
    typedef logic [9:0]  obj_entry_idx_t;
    typedef logic [13:0] obj_tile_code_t;
    typedef logic [11:0] obj_coord_t;
    typedef logic [7:0]  obj_colour_t;

    localparam int obj_words_per_entry = 8;
    localparam int obj_entry_count = 835;

    // word indexes inside one entry
    localparam int obj_tile_word = 0;
    localparam int obj_colour_word = 4;
    localparam int obj_x_word = 6;
    localparam int obj_y_word = 7;

    // x word flags
    localparam int obj_latch_extra_bit = 12;
    localparam int obj_latch_master_bit = 13;
    localparam int obj_no_extra_bit = 14;
    localparam int obj_absolute_bit = 15;

    // colour word flags
    localparam int obj_flip_x_bit = 8;
    localparam int obj_reuse_colour_bit = 10;
    localparam int obj_use_cur_y_bit = 12;
    localparam int obj_inc_y_bit = 13;
    localparam int obj_use_cur_x_bit = 14;
    localparam int obj_inc_x_bit = 15;

    // sequence step, one tile
    localparam int obj_seq_step = 16;

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_read_last,
        st_eval,
        st_check,
        st_tile_req,
        st_draw,
        st_next
    } walker_state_t;

endpackage

/* source/obj_position_eval.sv */
`timescale 1ns/1ns

module obj_position_eval (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 eval_start,
    input  obj_pkg::obj_word_t   x_word,
    input  obj_pkg::obj_word_t   y_word,
    input  obj_pkg::obj_word_t   colour_word,
    output obj_pkg::obj_coord_t  x,
    output obj_pkg::obj_coord_t  y,
    output obj_pkg::obj_colour_t colour,
    output logic                 flip_x
);
    import obj_pkg::*;

    obj_coord_t master_x;
    obj_coord_t master_y;
    obj_coord_t extra_x;
    obj_coord_t extra_y;
    obj_coord_t scroll_x;
    obj_coord_t scroll_y;
    obj_coord_t base_x;
    obj_coord_t base_y;
    obj_coord_t step_x;
    obj_coord_t step_y;

    always_comb begin
        scroll_x = '0;
        scroll_y = '0;
        // absolute entries ignore both scroll sets
        if (!x_word[obj_absolute_bit]) begin
            scroll_x = master_x;
            scroll_y = master_y;
            if (!x_word[obj_no_extra_bit]) begin
                scroll_x = master_x + extra_x;
                scroll_y = master_y + extra_y;
            end
        end
        base_x = x_word[$bits(obj_coord_t)-1:0] + scroll_x;
        base_y = y_word[$bits(obj_coord_t)-1:0] + scroll_y;
        step_x = colour_word[obj_inc_x_bit] ? obj_coord_t'(obj_seq_step) : '0;
        step_y = colour_word[obj_inc_y_bit] ? obj_coord_t'(obj_seq_step) : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            master_x <= '0;
            master_y <= '0;
            extra_x <= '0;
            extra_y <= '0;
            x <= '0;
            y <= '0;
        end else if (eval_start) begin
            if (x_word[obj_latch_master_bit]) begin
                master_x <= base_x;
                master_y <= base_y;
            end
            if (x_word[obj_latch_extra_bit]) begin
                extra_x <= base_x;
                extra_y <= base_y;
            end
            // sequence entries continue from the previous result
            x <= (colour_word[obj_use_cur_x_bit] ? base_x : x) + step_x;
            y <= (colour_word[obj_use_cur_y_bit] ? base_y : y) + step_y;
        end
    end

    always_ff @(posedge clk) begin
        if (eval_start) begin
            if (!colour_word[obj_reuse_colour_bit]) begin
                colour <= colour_word[$bits(obj_colour_t)-1:0];
            end
            flip_x <= colour_word[obj_flip_x_bit];
        end
    end

endmodule

/* source/obj_tile_shifter.sv */
`timescale 1ns/1ns

module obj_tile_shifter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tile_start,
    input  logic                 load,
    input  fb_pkg::fb_word_t     load_data,
    input  obj_pkg::obj_coord_t  x,
    input  obj_pkg::obj_coord_t  y,
    input  obj_pkg::obj_colour_t colour,
    input  logic                 flip_x,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [fb_pkg::fb_row_bits+fb_pkg::fb_col_bits-1:0] out_addr,
    output fb_pkg::fb_word_t     out_data,
    output fb_pkg::fb_be_t       out_be,
    output logic                 out_last
);
    import fb_pkg::*;

    // decoded tile, pixel 0 is the leftmost
    pixel_t [tile_size-1:0] tile_rows [tile_size];
    // current row after shift and mirror
    pixel_t [fb_pixels_per_word*shifter_cols-1:0] line_px;

    logic [4:0]             load_cnt;
    logic                   loaded;
    logic [3:0]             emit_row;
    logic [2:0]             emit_col;
    logic                   emit_done;
    logic                   advance;
    fb_word_t               next_data;
    fb_be_t                 next_be;
    logic [fb_row_bits-1:0] row_addr;
    logic [fb_col_bits-1:0] col_addr;

    // four 6 bit pixels from one 32 bit half
    function automatic logic [23:0] decode_half(input logic [31:0] d);
        logic [23:0] px;
        for (int k = 0; k < 4; k++) begin
            px[6*k +: 6] = {d[16 + 2*k +: 2], d[4*k +: 4]};
        end
        return px;
    endfunction

    // two loads per tile row, low half of each word first
    always_ff @(posedge clk) begin
        if (load) begin
            tile_rows[load_cnt[4:1]][8*load_cnt[0] +: 4] <= decode_half(load_data[31:0]);
            tile_rows[load_cnt[4:1]][8*load_cnt[0] + 4 +: 4] <= decode_half(load_data[63:32]);
        end
    end

    always_comb begin
        line_px = '0;
        for (int i = 0; i < tile_size; i++) begin
            if (flip_x) begin
                line_px[i + int'(x[1:0])] = tile_rows[emit_row][tile_size-1-i];
            end else begin
                line_px[i + int'(x[1:0])] = tile_rows[emit_row][i];
            end
        end
    end

    always_comb begin
        pixel_t px;
        for (int p = 0; p < fb_pixels_per_word; p++) begin
            px = line_px[fb_pixels_per_word*emit_col + p];
            next_data[16*p +: 16] = {4'b0000, colour[7:2], px};
            // zero pixels stay transparent
            next_be[2*p +: 2] = {2{|px}};
        end
    end

    assign row_addr = y[fb_row_bits-1:0] + fb_row_bits'(emit_row);
    assign col_addr = x[fb_col_bits+1:2] + fb_col_bits'(emit_col);

    // refill the output register whenever it is empty or being taken
    assign advance = loaded && !emit_done && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (reset || tile_start) begin
            load_cnt <= '0;
            loaded <= 1'b0;
            emit_row <= '0;
            emit_col <= '0;
            emit_done <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                load_cnt <= load_cnt + 5'd1;
                if (load_cnt == 5'(tile_burst_len - 1)) begin
                    loaded <= 1'b1;
                end
            end
            if (advance) begin
                out_valid <= 1'b1;
                emit_col <= emit_col + 3'd1;
                if (emit_col == 3'(shifter_cols - 1)) begin
                    emit_col <= '0;
                    emit_row <= emit_row + 4'd1;
                    if (emit_row == 4'(tile_size - 1)) begin
                        emit_done <= 1'b1;
                    end
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= next_data;
            out_be <= next_be;
            out_addr <= {row_addr, col_addr};
            out_last <= (emit_row == 4'(tile_size - 1)) && (emit_col == 3'(shifter_cols - 1));
        end
    end

endmodule

/* src.f */
source/obj_pkg.sv
source/fb_pkg.sv
source/obj_position_eval.sv
source/obj_tile_shifter.sv
source/obj_list_walker.sv
source/obj_engine.sv
sim/obj_mem_model.sv
sim/obj_engine_tb.sv
